// ==== build.f ====
logic/table_ad_pkg.sv
logic/table_cmd_pacer.sv
logic/table_ad_transmit.sv
logic/table_write_receiver.sv
logic/table_bank.sv
logic/table_ad_top.sv
tb/table_ad_assertions.sv
tb/table_ad_tb.sv

// ==== Makefile ====
# Verilator build and run for the table loading link

TOP := table_ad_tb

all: run

run:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// ==== tb/table_ad_tb.sv ====
// table loading link testbench
`timescale 1ns/1ps

module table_ad_tb
    import table_ad_pkg::*;
;
    localparam int NUM_CHANNELS    = 4;
    localparam int CHN_BITS        = 8;
    localparam int TABLE_ABITS     = 4;
    localparam int QUEUE_DEPTH     = 4;
    localparam int TABLE_DEPTH     = 1 << TABLE_ABITS;
    localparam int CH_W            = $clog2(NUM_CHANNELS);
    localparam int CLK_HALF        = 20;                      // 40 ns period
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_FIXED       = 12;                      // hand-written rows
    localparam int NUM_ROWS        = NUM_FIXED + 6;           // plus lcg rows
    localparam int ROW_CYCLES      = 40;                      // four commands, burst, readback
    localparam int SWEEP_CYCLES    = NUM_CHANNELS * TABLE_DEPTH * 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * ROW_CYCLES + SWEEP_CYCLES + 100;
    localparam cmd_t NO_CMD        = '0;                      // unused command slot

    // one stimulus row, commands go out on consecutive cycles
    typedef struct packed {
        logic [2:0]            n_cmd;       // commands used, 0 to 4
        cmd_t [3:0]            cmds;
        logic [CHN_BITS-1:0]   rd_chn;      // readback after busy falls
        logic [TABLE_ABITS-1:0] rd_addr;
        logic                  from_model;  // expected word taken from the table model
        logic [31:0]           exp_word;
    } row_t;

    logic                   clk;
    logic                   reset;
    logic                   cmd_we;
    cmd_t                   cmd;
    logic                   cmd_full;
    logic                   busy;
    logic [CHN_BITS-1:0]    rd_chn;
    logic [TABLE_ABITS-1:0] rd_addr;
    logic [31:0]            rd_data;

    row_t                   rows [NUM_ROWS];
    logic [31:0]            model_mem [NUM_CHANNELS][TABLE_DEPTH];  // expected tables
    logic                   written [NUM_CHANNELS][TABLE_DEPTH];    // entries with a known word
    logic [TABLE_ABITS-1:0] waddr_m [NUM_CHANNELS];                 // per-receiver word address
    logic [CHN_BITS-1:0]    sel_m;       // select of the last address command
    logic [31:0]            lcg_state;
    int                     errors;
    int                     tests;
    int                     failed;

    table_ad_top #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .CHN_BITS     (CHN_BITS),
        .TABLE_ABITS  (TABLE_ABITS),
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) table_ad_top_i (
        .clk      (clk),
        .reset    (reset),
        .cmd_we   (cmd_we),
        .cmd      (cmd),
        .cmd_full (cmd_full),
        .busy     (busy),
        .rd_chn   (rd_chn),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    bind table_ad_top table_ad_assertions #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) table_ad_assertions_i (
        .clk      (clk),
        .reset    (reset),
        .chn_en   (chn_en),
        .link     (link),
        .issue    (issue),
        .cmd_full (cmd_full),
        .pending  (pending)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic cmd_t addr_cmd(input logic [7:0] chn, input logic [23:0] addr);
        return '{a_not_d: 1'b1, payload: {chn, addr}};
    endfunction

    function automatic cmd_t data_cmd(input logic [31:0] word);
        return '{a_not_d: 1'b0, payload: word};
    endfunction

    function automatic row_t make_row(input int n, input cmd_t c0, input cmd_t c1,
                                      input cmd_t c2, input cmd_t c3, input logic [7:0] chn,
                                      input logic [3:0] addr, input logic [31:0] exp_word);
        row_t row;
        row.n_cmd      = 3'(n);
        row.cmds       = {c3, c2, c1, c0};  // slot 0 goes out first
        row.rd_chn     = chn;
        row.rd_addr    = addr;
        row.from_model = 1'b0;
        row.exp_word   = exp_word;
        return row;
    endfunction

    // address loads the low bits, data writes and steps the address
    task automatic apply_model(input cmd_t c);
        logic [CH_W-1:0] ch;
        if (c.a_not_d)
            sel_m = c.payload[31:24];
        ch = sel_m[CH_W-1:0];
        if (int'(sel_m) < NUM_CHANNELS) begin      // out-of-range select reaches no table
            if (c.a_not_d) begin
                waddr_m[ch] = c.payload[TABLE_ABITS-1:0];
            end else begin
                model_mem[ch][waddr_m[ch]] = c.payload;
                written[ch][waddr_m[ch]]   = 1'b1;
                waddr_m[ch]                = waddr_m[ch] + 1'b1;  // wraps at table depth
            end
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp_word,
                              input string what);
        assert (got === exp_word)
        else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got,
                     exp_word);
        end
    endtask

    task automatic build_fixed_rows;
        rows[0]  = make_row(2, addr_cmd(8'd1, 24'h000005), data_cmd(32'hA5A5_0101), NO_CMD,
                            NO_CMD, 8'd1, 4'd5, 32'hA5A5_0101);
        rows[1]  = make_row(4, addr_cmd(8'd2, 24'h00000E), data_cmd(32'h1111_2222),
                            data_cmd(32'h3333_4444), data_cmd(32'h5555_6666),
                            8'd2, 4'd0, 32'h5555_6666);  // third word wraps to zero
        rows[2]  = make_row(0, NO_CMD, NO_CMD, NO_CMD, NO_CMD, 8'd2, 4'd15, 32'h3333_4444);
        rows[3]  = make_row(2, addr_cmd(8'd2, 24'h000005), data_cmd(32'hDEAD_BEEF), NO_CMD,
                            NO_CMD, 8'd1, 4'd5, 32'hA5A5_0101);  // channel 1 untouched
        rows[4]  = make_row(0, NO_CMD, NO_CMD, NO_CMD, NO_CMD, 8'd2, 4'd5, 32'hDEAD_BEEF);
        rows[5]  = make_row(2, addr_cmd(8'd1, 24'h1234A6), data_cmd(32'hCAFE_0001), NO_CMD,
                            NO_CMD, 8'd1, 4'd6, 32'hCAFE_0001);  // only low bits select
        rows[6]  = make_row(4, addr_cmd(8'd3, 24'h000000), data_cmd(32'h7654_3210),
                            data_cmd(32'h89AB_CDEF), data_cmd(32'h0F1E_2D3C),
                            8'd3, 4'd2, 32'h0F1E_2D3C);
        rows[7]  = make_row(0, NO_CMD, NO_CMD, NO_CMD, NO_CMD, 8'd3, 4'd1, 32'h89AB_CDEF);
        rows[8]  = make_row(0, NO_CMD, NO_CMD, NO_CMD, NO_CMD, 8'd3, 4'd0, 32'h7654_3210);
        rows[9]  = make_row(2, addr_cmd(8'd5, 24'h000005), data_cmd(32'hBAD0_BAD0), NO_CMD,
                            NO_CMD, 8'd1, 4'd5, 32'hA5A5_0101);  // select 5 hits nothing
        rows[10] = make_row(2, addr_cmd(8'h80, 24'h000000), data_cmd(32'hBAD1_BAD1), NO_CMD,
                            NO_CMD, 8'h80, 4'd0, 32'h0000_0000);
        rows[11] = make_row(1, data_cmd(32'h1357_2468), NO_CMD, NO_CMD, NO_CMD,
                            8'd4, 4'd5, 32'h0000_0000);  // select still out of range
    endtask

    // lcg rows: one address command, then one to three data words
    task automatic build_random_rows;
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            lcg_state          = lcg_next(lcg_state);
            rows[r]            = '0;
            rows[r].n_cmd      = 3'(2 + int'(lcg_state[9:8]) % 3);
            rows[r].cmds[0]    = addr_cmd({6'd0, lcg_state[31:30]}, lcg_state[23:0]);
            rows[r].rd_chn     = {6'd0, lcg_state[31:30]};
            rows[r].rd_addr    = lcg_state[TABLE_ABITS-1:0];  // first word of the row
            rows[r].from_model = 1'b1;
            for (int i = 1; i < 4; i++) begin
                lcg_state       = lcg_next(lcg_state);
                rows[r].cmds[i] = data_cmd(lcg_state);
            end
        end
    endtask

    task automatic wait_idle;
        @(negedge clk);
        while (busy)
            @(negedge clk);                     // watchdog bounds this wait
    endtask

    task automatic run_row(input int r, input row_t row);
        int          err_before;
        logic [31:0] exp_word;
        err_before = errors;
        for (int i = 0; i < int'(row.n_cmd); i++) begin
            @(posedge clk);
            cmd_we <= 1'b1;
            cmd    <= row.cmds[i];
            apply_model(row.cmds[i]);
        end
        if (row.n_cmd != 3'd0) begin
            @(posedge clk);
            cmd_we <= 1'b0;
            cmd    <= '0;
        end
        wait_idle();
        assert (!cmd_full)
        else begin
            errors++;
            $display("CHECK FAILED at %0t ns: row %0d cmd_full high after busy fell", $time, r);
        end
        @(posedge clk);
        rd_chn  <= row.rd_chn;
        rd_addr <= row.rd_addr;
        @(negedge clk);                         // readback is combinational
        exp_word = row.from_model ? model_mem[row.rd_chn[CH_W-1:0]][row.rd_addr] : row.exp_word;
        check_word(rd_data, exp_word, $sformatf("row %0d readback chn %0d addr %0d", r,
                   row.rd_chn, row.rd_addr));
        tests++;
        if (errors == err_before) begin
            $display("row %0d passed, %0d commands", r, row.n_cmd);
        end else begin
            failed++;
            $display("row %0d failed", r);
        end
    endtask

    // every entry with a known word, in every channel
    task automatic sweep_tables;
        int err_before;
        err_before = errors;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int a = 0; a < TABLE_DEPTH; a++) begin
                if (written[c][a]) begin
                    @(posedge clk);
                    rd_chn  <= CHN_BITS'(c);
                    rd_addr <= TABLE_ABITS'(a);
                    @(negedge clk);
                    check_word(rd_data, model_mem[c][a], $sformatf("sweep chn %0d addr %0d",
                               c, a));
                end
            end
        end
        tests++;
        if (errors == err_before) begin
            $display("table sweep passed");
        end else begin
            failed++;
            $display("table sweep failed");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, the DUT did not finish the tests in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        cmd_we    = 1'b0;
        cmd       = '0;
        rd_chn    = '0;
        rd_addr   = '0;
        sel_m     = '0;                         // transmitter select after reset
        lcg_state = 32'h7c78;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            waddr_m[c] = '0;
            for (int a = 0; a < TABLE_DEPTH; a++)
                written[c][a] = 1'b0;
        end
        build_fixed_rows();
        build_random_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r, rows[r]);
        sweep_tables();
        $display("tests %0d, failed %0d, check errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tb/table_ad_assertions.sv ====
// link and pacer timing assertions
`timescale 1ns/1ps

module table_ad_assertions
    import table_ad_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input logic                    clk,
    input logic                    reset,
    input logic [NUM_CHANNELS-1:0] chn_en,    // receiver byte enables
    input link_t                   link,      // byte link
    input logic                    issue,     // pacer issue strobe
    input logic                    cmd_full,  // pacer queue full
    input logic                    pending    // pacer queue not empty
);
    localparam int SINCE_W = $clog2(MIN_CMD_GAP + 1);

    logic [SINCE_W-1:0] since_issue;  // cycles since the last issue, saturates at the gap

    always_ff @(posedge clk) begin
        if (reset)
            since_issue <= SINCE_W'(MIN_CMD_GAP);  // first issue always allowed
        else if (issue)
            since_issue <= SINCE_W'(1);
        else if (since_issue != SINCE_W'(MIN_CMD_GAP))
            since_issue <= since_issue + 1'b1;
    end

    // a burst stays on one receiver
    enable_steady: assert property (@(posedge clk) disable iff (reset)
        ((|chn_en) && (|$past(chn_en))) |-> $stable(chn_en))
        else $error("channel enable changed during a burst");

    // burst type cannot change inside a burst
    burst_type_stable: assert property (@(posedge clk) disable iff (reset)
        ((|chn_en) && (|$past(chn_en))) |-> $stable(link.a_not_d))
        else $error("link burst type changed during a burst");

    issue_spacing: assert property (@(posedge clk) disable iff (reset)
        issue |-> (since_issue >= SINCE_W'(MIN_CMD_GAP)))
        else $error("issue strobes closer than the minimum gap");

    // the queue only shrinks by issuing its head
    queue_drains_by_issue: assert property (@(posedge clk) disable iff (reset)
        ($fell(cmd_full) || $fell(pending)) |-> issue)
        else $error("queue level fell without an issue strobe");

endmodule

// ==== logic/table_ad_top.sv ====
// table loading link top level
`timescale 1ns/1ps

module table_ad_top
    import table_ad_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int CHN_BITS     = 8,
    parameter int TABLE_ABITS  = 4,
    parameter int QUEUE_DEPTH  = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmd_we,    // host command strobe
    input  cmd_t                   cmd,       // host command, valid with cmd_we
    output logic                   cmd_full,  // queue full, writes dropped
    output logic                   busy,      // queued, sending or finishing a write
    input  logic [CHN_BITS-1:0]    rd_chn,
    input  logic [TABLE_ABITS-1:0] rd_addr,
    output logic [31:0]            rd_data
);
    logic                    issue;
    cmd_t                    issue_cmd;
    logic                    pending;    // pacer queue not empty
    link_t                   link;
    logic [NUM_CHANNELS-1:0] chn_en;
    logic                    active;     // transmitter burst
    logic                    writing;    // receiver last byte

    table_cmd_pacer #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) table_cmd_pacer_i (
        .clk       (clk),
        .reset     (reset),
        .cmd_we    (cmd_we),
        .cmd       (cmd),
        .cmd_full  (cmd_full),
        .issue     (issue),
        .issue_cmd (issue_cmd),
        .pending   (pending)
    );

    table_ad_transmit #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .CHN_BITS     (CHN_BITS)
    ) table_ad_transmit_i (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .issue_cmd (issue_cmd),
        .link      (link),
        .chn_en    (chn_en),
        .active    (active)
    );

    table_bank #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .CHN_BITS     (CHN_BITS),
        .TABLE_ABITS  (TABLE_ABITS)
    ) table_bank_i (
        .clk     (clk),
        .reset   (reset),
        .link    (link),
        .chn_en  (chn_en),
        .rd_chn  (rd_chn),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .writing (writing)
    );

    assign busy = pending || active || writing;  // falls once the table is updated

endmodule

// ==== logic/table_bank.sv ====
// table bank with channel receivers
`timescale 1ns/1ps

module table_bank
    import table_ad_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int CHN_BITS     = 8,
    parameter int TABLE_ABITS  = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  link_t                   link,     // shared by all receivers
    input  logic [NUM_CHANNELS-1:0] chn_en,   // per-receiver byte enable
    input  logic [CHN_BITS-1:0]     rd_chn,   // readback channel
    input  logic [TABLE_ABITS-1:0]  rd_addr,  // readback word address
    output logic [31:0]             rd_data,  // zero for a channel out of range
    output logic                    writing   // any receiver finishing a burst
);
    logic [31:0]             chn_rd [NUM_CHANNELS];  // readback word per channel
    logic [NUM_CHANNELS-1:0] chn_writing;

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_rx
        table_write_receiver #(
            .TABLE_ABITS (TABLE_ABITS)
        ) table_write_receiver_i (
            .clk     (clk),
            .reset   (reset),
            .en      (chn_en[i]),
            .link    (link),
            .rd_addr (rd_addr),
            .rd_data (chn_rd[i]),
            .writing (chn_writing[i])
        );
    end

    // readback mux by channel, no match leaves zero
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (rd_chn == CHN_BITS'(i))
                rd_data = chn_rd[i];
        end
    end

    assign writing = |chn_writing;

endmodule

// ==== logic/table_write_receiver.sv ====
// per-channel table write receiver
`timescale 1ns/1ps

module table_write_receiver
    import table_ad_pkg::*;
#(
    parameter int TABLE_ABITS = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,       // this channel takes the byte on the link
    input  link_t                  link,
    input  logic [TABLE_ABITS-1:0] rd_addr,  // readback address
    output logic [31:0]            rd_data,  // combinational readback
    output logic                   writing   // last byte, table or address update at edge
);
    localparam int DEPTH  = 1 << TABLE_ABITS;
    localparam int BCNT_W = $clog2(DATA_BYTES);

    logic [31:0]            table_mem [DEPTH];
    logic [31:0]            word_r;      // bytes collected so far
    logic [31:0]            word_next;   // word_r with the current byte placed
    logic [BCNT_W-1:0]      byte_cnt;    // index of the current byte
    logic [TABLE_ABITS-1:0] waddr;       // word address for the next data burst
    logic                   last_byte;

    // lsb first, byte k lands in bits 8k+7..8k
    always_comb begin
        word_next                     = word_r;
        word_next[byte_cnt * 8 +: 8]  = link.ser_d;
    end

    assign last_byte = link.a_not_d ? (byte_cnt == BCNT_W'(ADDR_BYTES - 1))
                                    : (byte_cnt == BCNT_W'(DATA_BYTES - 1));
    assign writing   = en && last_byte;
    assign rd_data   = table_mem[rd_addr];

    always_ff @(posedge clk) begin
        if (en)
            word_r <= word_next;
        if (writing && !link.a_not_d)
            table_mem[waddr] <= word_next;   // full word includes the last byte
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt <= '0;
            waddr    <= '0;
        end else if (en) begin
            if (last_byte) begin
                byte_cnt <= '0;              // ready for the next burst
                if (link.a_not_d)
                    waddr <= word_next[TABLE_ABITS-1:0];  // low bits of byte address
                else
                    waddr <= waddr + 1'b1;   // wraps at table depth
            end else begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/table_ad_transmit.sv ====
// byte-wide table address and data transmitter
`timescale 1ns/1ps

module table_ad_transmit
    import table_ad_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int CHN_BITS     = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue,      // single cycle command strobe
    input  cmd_t                    issue_cmd,  // valid with issue
    output link_t                   link,       // byte and burst type
    output logic [NUM_CHANNELS-1:0] chn_en,     // one-hot or zero, one byte per cycle
    output logic                    active      // strobe through end of burst
);
    localparam int BCNT_W = $clog2(DATA_BYTES);

    logic [31:0]             d_r;        // shift register, lsb byte on the link
    logic                    a_not_d_r;  // burst type of the current command
    logic [CHN_BITS-1:0]     sel_a;      // channel select from last address command
    logic [NUM_CHANNELS-1:0] sel;        // one-hot decode of sel_a
    logic                    we_r;       // address command, select just registered
    logic                    any_en;     // burst running, even with no channel selected
    logic [BCNT_W-1:0]       byte_cnt;   // bytes left after the current one
    logic                    start;      // first byte of a burst on the next cycle

    assign link   = '{ser_d: d_r[7:0], a_not_d: a_not_d_r};
    assign start  = (issue && !issue_cmd.a_not_d) || we_r;  // address waits for the select
    assign active = issue || we_r || any_en;

    // out-of-range select matches no channel
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++)
            sel[i] = (sel_a == CHN_BITS'(i));
    end

    always_ff @(posedge clk) begin
        if (issue)
            d_r <= issue_cmd.payload;
        else if (any_en)
            d_r <= d_r >> 8;                 // next byte down
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a_not_d_r <= 1'b0;
            we_r      <= 1'b0;
            sel_a     <= '0;
            any_en    <= 1'b0;
            chn_en    <= '0;
            byte_cnt  <= '0;
        end else begin
            if (issue)
                a_not_d_r <= issue_cmd.a_not_d;
            we_r <= issue && issue_cmd.a_not_d;
            if (issue && issue_cmd.a_not_d)
                sel_a <= issue_cmd.payload[24 +: CHN_BITS];
            if (start) begin
                any_en   <= 1'b1;
                chn_en   <= sel;
                byte_cnt <= we_r ? BCNT_W'(ADDR_BYTES - 1) : BCNT_W'(DATA_BYTES - 1);
            end else if (any_en) begin
                if (byte_cnt == '0) begin    // last byte on the link now
                    any_en <= 1'b0;
                    chn_en <= '0;
                end else begin
                    byte_cnt <= byte_cnt - 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/table_cmd_pacer.sv ====
// command pacer queue
`timescale 1ns/1ps

module table_cmd_pacer
    import table_ad_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic cmd_we,     // single cycle write strobe from the host
    input  cmd_t cmd,        // valid with cmd_we
    output logic cmd_full,   // queue holds QUEUE_DEPTH entries, writes are dropped
    output logic issue,      // single cycle, at least MIN_CMD_GAP apart
    output cmd_t issue_cmd,  // valid with issue
    output logic pending     // queue not empty
);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int GAP_W = $clog2(MIN_CMD_GAP);

    cmd_t             queue_mem [QUEUE_DEPTH];  // circular buffer
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                    // entries held
    logic [GAP_W-1:0] gap_cnt;                  // cycles left before next issue allowed
    logic             push;
    logic             pop;

    // wrap a queue pointer at the last entry
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign cmd_full = (count == CNT_W'(QUEUE_DEPTH));
    assign pending  = (count != '0);
    assign push     = cmd_we && !cmd_full;     // write while full is lost
    assign pop      = pending && (gap_cnt == '0);

    // queue storage and issued command, payload only
    always_ff @(posedge clk) begin
        if (push)
            queue_mem[wr_ptr] <= cmd;
        if (pop)
            issue_cmd <= queue_mem[rd_ptr];    // head moves to the transmitter
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            gap_cnt <= '0;
            issue   <= 1'b0;
        end else begin
            issue <= pop;
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop) begin
                rd_ptr  <= ptr_next(rd_ptr);
                gap_cnt <= GAP_W'(MIN_CMD_GAP - 1);  // strobe plus 5 quiet cycles
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // none, or push and pop together
            endcase
        end
    end

endmodule

// ==== logic/table_ad_pkg.sv ====
// table link shared definitions
package table_ad_pkg;

    // burst lengths on the byte link
    localparam int ADDR_BYTES  = 3;  // 24-bit byte address, select byte is not sent
    localparam int DATA_BYTES  = 4;  // full 32-bit table word

    // minimum spacing between two issue strobes, in clock cycles
    localparam int MIN_CMD_GAP = 6;

    // host command as queued by the pacer
    typedef struct packed {
        logic        a_not_d;  // 1: address command, 0: data command
        logic [31:0] payload;  // {chn_sel[7:0], byte_addr[23:0]} or data word
    } cmd_t;

    // byte link from the transmitter to every receiver
    typedef struct packed {
        logic [7:0] ser_d;    // current byte, lsb first
        logic       a_not_d;  // burst type, held for the whole burst
    } link_t;

endpackage
